/* Bender.yml */
package:
  name: spy_mon

dependencies: {}

sources:
  # packages first, the control package imports the monitor package
  - files:
      - hdl/spy_mon_pkg.sv
      - hdl/spy_ctrl_pkg.sv
      - hdl/spy_init_seq.sv
      - hdl/spy_port_mux.sv
      - hdl/spy_buffer.sv
      - hdl/spy_mon_top.sv

  - target: test
    files:
      - bench/tb_spy_mon.sv

/* bench/tb_spy_mon.sv */
module tb_spy_mon
   import spy_mon_pkg::*;
   import spy_ctrl_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int sb_num       = 4;
   localparam int mem_aw       = 6;
   localparam int depth        = 2**mem_aw;
   localparam int rst_cycles   = 16;
   localparam int sweep_cycles = 64;                   // one address per cycle
   localparam int rd_all_len   = depth + 1;            // one read per address plus last rsp
   localparam int t1_len       = sweep_cycles + rd_all_len;
   localparam int t2_len       = 40 + rd_all_len;
   localparam int t3_len       = 30 + rd_all_len;
   localparam int t4_len       = 3 * 32 + 2 + rd_all_len;
   localparam int t5_len       = 1 + sweep_cycles + 2 * rd_all_len + 2;
   localparam int wd_cycles    = 2 * (rst_cycles + t1_len + t2_len + t3_len + t4_len + t5_len)
                                 + 1500;               // margin for a run of roughly 3000

   logic              spy_clock;
   logic              axi_reset;
   logic              init_spy_mem_i;
   logic [sb_num-1:0] freeze;
   logic              init_busy;
   mon_word_t         mon      [sb_num];
   spy_host_req_t     host_req [sb_num];
   spy_host_rsp_t     host_rsp [sb_num];

   // reference model state
   logic [spy_data_w-1:0] m_mem   [sb_num][depth];
   logic [mem_aw-1:0]     m_ptr   [sb_num];            // capture pointer per buffer
   logic                  m_busy;                      // model of the init sweep
   logic [spy_addr_w-1:0] m_addr;
   spy_host_rsp_t         exp_rsp [sb_num];            // expected response next cycle
   logic [spy_addr_w-1:0] rw_addr [sb_num];            // last host write address per buffer

   integer seed = 94972;
   string  test_name = "reset";
   int     err_cnt = 0;
   int     err_at_start;
   int     tests_run = 0;
   int     tests_failed = 0;

   spy_mon_top #(
      .sb_num (sb_num),
      .mem_aw (mem_aw)
   ) u_dut (
      .spy_clock      (spy_clock),
      .axi_reset      (axi_reset),
      .mon_i          (mon),
      .freeze_i       (freeze),
      .init_spy_mem_i (init_spy_mem_i),
      .host_req_i     (host_req),
      .host_rsp_o     (host_rsp),
      .init_busy_o    (init_busy)
   );

   initial
   begin
      spy_clock = 1'b0;
      forever
      begin
         #5 spy_clock = ~spy_clock;                    // 10 ns period
      end
   end

   // reads see the model memory before this edge's writes
   always @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         m_busy <= 1'b1;                               // sweep starts out of reset
         m_addr <= '0;
         for (int b = 0; b < sb_num; b++)
         begin
            m_ptr[b]   <= '0;
            exp_rsp[b] <= '0;
         end
      end
      else
      begin
         for (int b = 0; b < sb_num; b++)
         begin
            if (host_req[b].op == op_read && !m_busy)
            begin
               exp_rsp[b].rd_data <= m_mem[b][host_req[b].addr];
               exp_rsp[b].rd_vld  <= 1'b1;
            end
            else
            begin
               exp_rsp[b] <= '0;                       // zero data when nothing was read
            end
            if (mon[b].valid && !freeze[b])
            begin
               m_mem[b][m_ptr[b]] <= mon[b].data;
               m_ptr[b]           <= m_ptr[b] + 1'b1;  // wraps at depth
            end
            if (m_busy)
            begin
               m_mem[b][m_addr] <= '0;                 // later nba wins over capture
            end
            else if (host_req[b].op == op_write)
            begin
               m_mem[b][host_req[b].addr] <= host_req[b].wr_data;
            end
         end
         if (m_busy)
         begin
            m_addr <= m_addr + 1'b1;
            if (m_addr == sweep_cycles - 1)
            begin
               m_busy <= 1'b0;
            end
         end
         else if (init_spy_mem_i)
         begin
            m_busy <= 1'b1;                            // restart only from idle
         end
      end
   end

   for (genvar b = 0; b < sb_num; b++)
   begin : g_chk
      a_rsp_match : assert property (
         @(posedge spy_clock) disable iff (axi_reset)
         host_rsp[b] == exp_rsp[b]
      ) else
      begin
         $display("ERROR %s buf %0d expected data %h vld %b actual data %h vld %b",
                  test_name, b, $sampled(exp_rsp[b].rd_data), $sampled(exp_rsp[b].rd_vld),
                  $sampled(host_rsp[b].rd_data), $sampled(host_rsp[b].rd_vld));
         err_cnt++;
      end
      // gating holds regardless of the model
      a_zero_gate : assert property (
         @(posedge spy_clock) disable iff (axi_reset)
         !host_rsp[b].rd_vld |-> (host_rsp[b].rd_data == '0)
      ) else
      begin
         $display("%s: buffer %0d drove nonzero read data without read-valid", test_name, b);
         err_cnt++;
      end
      a_no_vld_sweep : assert property (
         @(posedge spy_clock) disable iff (axi_reset)
         init_busy |=> !host_rsp[b].rd_vld
      ) else
      begin
         $display("%s: buffer %0d raised read-valid after an init cycle", test_name, b);
         err_cnt++;
      end
   end

   a_busy_match : assert property (
      @(posedge spy_clock) disable iff (axi_reset)
      init_busy == m_busy
   ) else
   begin
      $display("ERROR %s init_busy expected %b actual %b",
               test_name, $sampled(m_busy), $sampled(init_busy));
      err_cnt++;
   end

   // inputs change 1 ns after the edge and requests last one cycle
   task automatic next_cycle();
      @(posedge spy_clock);
      #1;
      init_spy_mem_i = 1'b0;
      for (int b = 0; b < sb_num; b++)
      begin
         host_req[b] = '0;
         mon[b]      = '0;
      end
   endtask

   task automatic start_test(input string name);
      test_name    = name;
      err_at_start = err_cnt;
      tests_run++;
   endtask

   task automatic finish_test();
      if (err_cnt == err_at_start)
      begin
         $display("[%s] ok", test_name);
      end
      else
      begin
         $display("[%s] failed with %0d errors", test_name, err_cnt - err_at_start);
         tests_failed++;
      end
   endtask

   // every buffer reads the same address each cycle
   task automatic read_all();
      for (int a = 0; a < depth; a++)
      begin
         for (int b = 0; b < sb_num; b++)
         begin
            host_req[b].op   = op_read;
            host_req[b].addr = a;
         end
         next_cycle();
      end
      next_cycle();                                    // last response
   endtask

   // host keeps reading while the sweep runs and the sweep length is checked after
   task automatic sweep_with_reads();
      int busy_cnt;
      busy_cnt = 0;
      while (init_busy)
      begin
         for (int b = 0; b < sb_num; b++)
         begin
            host_req[b].op   = op_read;
            host_req[b].addr = $random(seed);
         end
         busy_cnt++;
         next_cycle();
      end
      assert (busy_cnt == sweep_cycles)
      else
      begin
         $display("ERROR %s sweep cycles expected %0d actual %0d",
                  test_name, sweep_cycles, busy_cnt);
         err_cnt++;
      end
   endtask

   task automatic push_words(input int b, input int n, input bit rand_valid);
      for (int i = 0; i < n; i++)
      begin
         mon[b].data  = $random(seed);
         mon[b].valid = rand_valid ? $random(seed) : 1'b1;
         next_cycle();
      end
   endtask

   initial
   begin
      repeat (wd_cycles) @(posedge spy_clock);
      $display("watchdog expired after %0d cycles in %s, the run did not finish",
               wd_cycles, test_name);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      axi_reset      = 1'b1;
      init_spy_mem_i = 1'b0;
      freeze         = '0;
      for (int b = 0; b < sb_num; b++)
      begin
         host_req[b] = '0;
         mon[b]      = '0;
      end
      repeat (rst_cycles) @(posedge spy_clock);
      #1 axi_reset = 1'b0;

      start_test("reset_sweep");
      sweep_with_reads();
      read_all();                                      // everything reads zero
      finish_test();

      start_test("capture");
      push_words(0, 40, 1'b1);                         // some words invalid
      read_all();
      finish_test();

      start_test("freeze");
      freeze[1] = 1'b1;
      push_words(1, 20, 1'b0);
      freeze[1] = 1'b0;
      push_words(1, 10, 1'b0);                         // resumes at held pointer
      read_all();
      finish_test();

      start_test("host_rw");
      for (int i = 0; i < 32; i++)
      begin
         for (int b = 0; b < sb_num; b++)
         begin
            rw_addr[b]          = $random(seed);
            host_req[b].op      = op_write;
            host_req[b].addr    = rw_addr[b];
            host_req[b].wr_data = $random(seed);
         end
         next_cycle();
         for (int b = 0; b < sb_num; b++)
         begin
            host_req[b].op   = op_read;                // fresh word into the read register
            host_req[b].addr = rw_addr[b];
         end
         next_cycle();
         next_cycle();                                 // no request, held word must stay gated
      end
      mon[0].data          = $random(seed);            // host write beats capture here
      mon[0].valid         = 1'b1;
      host_req[0].op       = op_write;
      host_req[0].addr     = m_ptr[0];
      host_req[0].wr_data  = $random(seed);
      next_cycle();
      read_all();
      finish_test();

      start_test("init_request");
      init_spy_mem_i = 1'b1;
      next_cycle();
      sweep_with_reads();
      read_all();
      push_words(0, 1, 1'b0);                          // lands at unchanged pointer
      push_words(1, 1, 1'b0);
      read_all();
      finish_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0 && tests_failed == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule : tb_spy_mon

/* hdl/spy_buffer.sv */
module spy_buffer
   import spy_mon_pkg::*;
   import spy_ctrl_pkg::*;
#(
   parameter int mem_aw = 6                            // used address bits, <= spy_addr_w
)
(
   input  logic                  spy_clock,
   input  logic                  axi_reset,
   input  mon_word_t             mon_i,                // monitor stream
   input  logic                  freeze_i,             // stop capturing
   input  spy_host_req_t         mem_req_i,            // host or init request
   output logic [spy_data_w-1:0] mem_rd_data_o         // registered read word
);

   localparam int depth = 2**mem_aw;

   logic [spy_data_w-1:0] mem [depth];                 // spy memory
   logic [mem_aw-1:0]     cap_ptr;                     // next capture slot
   logic [mem_aw-1:0]     host_addr;
   logic [spy_data_w-1:0] rd_data;
   logic                  cap_we;
   logic                  host_we;
   logic                  host_re;
   logic                  cap_hit;                     // capture would land on host write

   assign host_addr = mem_req_i.addr[mem_aw-1:0];      // upper bits unused for small buffers
   assign host_we   = (mem_req_i.op == op_write);
   assign host_re   = (mem_req_i.op == op_read);
   assign cap_we    = mon_i.valid && !freeze_i;        // invalid words skipped
   assign cap_hit   = host_we && (host_addr == cap_ptr);

   // capture pointer, only reset moves it back, a sweep leaves it alone
   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         cap_ptr <= '0;
      end
      else if (cap_we)
      begin
         cap_ptr <= cap_ptr + 1'b1;                    // wraps at depth
      end
   end

   // capture port, steps aside when the host writes the same word
   always_ff @(posedge spy_clock)
   begin
      if (cap_we && !cap_hit)
      begin
         mem[cap_ptr] <= mon_i.data;
      end
      if (host_we)
      begin
         mem[host_addr] <= mem_req_i.wr_data;          // host or init zero write
      end
   end

   // host read register, data valid the cycle after op_read
   always_ff @(posedge spy_clock)
   begin
      if (host_re)
      begin
         rd_data <= mem[host_addr];
      end
   end

   assign mem_rd_data_o = rd_data;

   // frozen buffer keeps its slot for when capture resumes
   a_freeze_holds_ptr : assert property (
      @(posedge spy_clock) disable iff (axi_reset)
      freeze_i |=> $stable(cap_ptr)
   );

endmodule : spy_buffer

/* hdl/spy_ctrl_pkg.sv */
package spy_ctrl_pkg;

   import spy_mon_pkg::*;

   // host port operation, one cycle strobe
   typedef enum logic [1:0]
   {
      op_none  = 2'd0,                                 // idle cycle
      op_read  = 2'd1,                                 // data back one cycle later
      op_write = 2'd2                                  // stored at end of cycle
   } spy_op_e;

   // host request toward one buffer
   typedef struct packed
   {
      spy_op_e               op;                       // 2 bits
      logic [spy_addr_w-1:0] addr;                     // word address
      logic [spy_data_w-1:0] wr_data;                  // only meaningful for op_write
   } spy_host_req_t;

   // host response from one buffer
   typedef struct packed
   {
      logic [spy_data_w-1:0] rd_data;                  // zero unless rd_vld
      logic                  rd_vld;                   // registered, follows op_read
   } spy_host_rsp_t;

endpackage : spy_ctrl_pkg

/* hdl/spy_init_seq.sv */
module spy_init_seq
   import spy_mon_pkg::*;
(
   input  logic                  spy_clock,
   input  logic                  axi_reset,
   input  logic                  init_spy_mem_i,   // request a new sweep
   output logic                  init_busy_o,      // high for the whole sweep
   output logic [spy_addr_w-1:0] init_addr_o       // shared by every buffer
);

   localparam logic [spy_addr_w-1:0] last_addr = {spy_addr_w{1'b1}};

   init_state_e           state;
   logic [spy_addr_w-1:0] init_addr;

   // one counter serves all buffers, they all clear the same address together
   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         state     <= st_sweep;                        // sweep straight out of reset
         init_addr <= '0;
      end
      else
      begin
         case (state)
            st_sweep:
            begin
               init_addr <= init_addr + 1'b1;          // wraps to 0 after last_addr
               if (init_addr == last_addr)
               begin
                  state <= st_idle;                    // 64 cycles done
               end
            end
            st_idle:
            begin
               if (init_spy_mem_i)
               begin
                  state <= st_sweep;                   // addr already back at 0
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   assign init_busy_o = (state == st_sweep);
   assign init_addr_o = init_addr;

   // a sweep never starts part way through the address space
   a_sweep_from_zero : assert property (
      @(posedge spy_clock) disable iff (axi_reset)
      (state == st_sweep && $past(state) == st_idle) |-> (init_addr == '0)
   );

endmodule : spy_init_seq

/* hdl/spy_mon_pkg.sv */
package spy_mon_pkg;

   // widths shared by the monitor path and the host port
   localparam int unsigned spy_data_w = 32;            // host bus data width
   localparam int unsigned spy_addr_w = 6;             // host address width, 64 word sweep

   // one monitor word as it arrives from the trigger path
   typedef struct packed
   {
      logic [spy_data_w-1:0] data;                     // captured payload
      logic                  valid;                    // word present this cycle
   } mon_word_t;

   // init sweep sequencer states
   typedef enum logic
   {
      st_sweep = 1'b0,                                 // writing zeros, one addr per cycle
      st_idle  = 1'b1                                  // waiting for an init request
   } init_state_e;

endpackage : spy_mon_pkg

/* hdl/spy_mon_top.sv */
module spy_mon_top
   import spy_mon_pkg::*;
   import spy_ctrl_pkg::*;
#(
   parameter int sb_num = 4,                           // buffer count
   parameter int mem_aw = 6                            // address bits per buffer
)
(
   input  logic          spy_clock,
   input  logic          axi_reset,
   input  mon_word_t     mon_i      [sb_num],          // one stream per buffer
   input  logic [sb_num-1:0] freeze_i,
   input  logic          init_spy_mem_i,               // restart the clear sweep
   input  spy_host_req_t host_req_i [sb_num],
   output spy_host_rsp_t host_rsp_o [sb_num],
   output logic          init_busy_o
);

   logic                  init_busy;
   logic [spy_addr_w-1:0] init_addr;
   spy_host_req_t         mem_req     [sb_num];        // effective request per buffer
   logic [spy_data_w-1:0] mem_rd_data [sb_num];

   spy_init_seq u_init_seq (
      .spy_clock      (spy_clock),
      .axi_reset      (axi_reset),
      .init_spy_mem_i (init_spy_mem_i),
      .init_busy_o    (init_busy),
      .init_addr_o    (init_addr)
   );

   spy_port_mux #(
      .sb_num (sb_num)
   ) u_port_mux (
      .spy_clock     (spy_clock),
      .axi_reset     (axi_reset),
      .init_busy_i   (init_busy),
      .init_addr_i   (init_addr),
      .host_req_i    (host_req_i),
      .mem_rd_data_i (mem_rd_data),
      .mem_req_o     (mem_req),
      .host_rsp_o    (host_rsp_o)
   );

   for (genvar sb_i = 0; sb_i < sb_num; sb_i++)
   begin : g_spy_buf
      spy_buffer #(
         .mem_aw (mem_aw)
      ) u_spy_buffer (
         .spy_clock     (spy_clock),
         .axi_reset     (axi_reset),
         .mon_i         (mon_i[sb_i]),
         .freeze_i      (freeze_i[sb_i]),
         .mem_req_i     (mem_req[sb_i]),
         .mem_rd_data_o (mem_rd_data[sb_i])
      );
   end

   assign init_busy_o = init_busy;                     // sweep status to the host side

endmodule : spy_mon_top

/* hdl/spy_port_mux.sv */
module spy_port_mux
   import spy_mon_pkg::*;
   import spy_ctrl_pkg::*;
#(
   parameter int sb_num = 4                            // number of spy buffers
)
(
   input  logic                  spy_clock,
   input  logic                  axi_reset,
   input  logic                  init_busy_i,          // sweep in progress
   input  logic [spy_addr_w-1:0] init_addr_i,          // sweep address
   input  spy_host_req_t         host_req_i    [sb_num],
   input  logic [spy_data_w-1:0] mem_rd_data_i [sb_num],  // buffer read registers
   output spy_host_req_t         mem_req_o     [sb_num],
   output spy_host_rsp_t         host_rsp_o    [sb_num]
);

   logic [sb_num-1:0] rd_vld;                          // one per buffer

   // init owns every memory port while the sweep runs
   always_comb
   begin
      for (int i = 0; i < sb_num; i++)
      begin
         if (init_busy_i)
         begin
            mem_req_o[i].op      = op_write;           // zero write
            mem_req_o[i].addr    = init_addr_i;
            mem_req_o[i].wr_data = '0;
         end
         else
         begin
            mem_req_o[i] = host_req_i[i];              // host passes straight through
         end
      end
   end

   // read valid lines up with the buffer's registered read data
   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         rd_vld <= '0;
      end
      else
      begin
         for (int i = 0; i < sb_num; i++)
         begin
            rd_vld[i] <= (host_req_i[i].op == op_read) && !init_busy_i;  // no reads in sweep
         end
      end
   end

   // zero data whenever the response is not valid
   always_comb
   begin
      for (int i = 0; i < sb_num; i++)
      begin
         host_rsp_o[i].rd_vld = rd_vld[i];
         if (rd_vld[i])
         begin
            host_rsp_o[i].rd_data = mem_rd_data_i[i];
         end
         else
         begin
            host_rsp_o[i].rd_data = '0;
         end
      end
   end

   // a host read issued during the sweep must come back invalid
   a_no_vld_after_init : assert property (
      @(posedge spy_clock) disable iff (axi_reset)
      init_busy_i |=> (rd_vld == '0)
   );

endmodule : spy_port_mux

/* tb.f */
hdl/spy_mon_pkg.sv
hdl/spy_ctrl_pkg.sv
hdl/spy_init_seq.sv
hdl/spy_port_mux.sv
hdl/spy_buffer.sv
hdl/spy_mon_top.sv
bench/tb_spy_mon.sv
